// ==== design/ccc_frame_parser.sv ====
// Bytes outside a frame are dropped; data bytes past the limit are dropped and flag an error
`timescale 1ns/10ps

module ccc_frame_parser (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    frame_start_i,
  input  logic                    frame_end_i,
  input  i3c_ccc_pkg::ccc_byte_t  byte_i,
  input  logic                    byte_valid_i,
  input  logic                    needs_defining_byte_i,
  input  i3c_ccc_pkg::ccc_count_t command_max_bytes_i,
  output i3c_ccc_pkg::ccc_byte_t  command_code_o,
  output logic                    command_code_valid_o,
  output i3c_ccc_pkg::ccc_byte_t  defining_byte_o,
  output logic                    defining_byte_valid_o,
  output i3c_ccc_pkg::ccc_byte_t  command_data_o,
  output logic                    command_data_valid_o,
  output logic                    frame_done_o,
  output logic                    protocol_error_o
);

  i3c_ccc_pkg::parser_state_e state_q, state_d;
  i3c_ccc_pkg::ccc_count_t    data_cnt_q, data_cnt_d;
  i3c_ccc_pkg::ccc_byte_t     byte_q;

  logic code_valid_q, code_valid_d;
  logic def_valid_q, def_valid_d;
  logic data_valid_q, data_valid_d;
  logic frame_done_q, frame_done_d;
  logic error_q, error_d;
  logic take_data;

  always_comb begin
    state_d      = state_q;
    data_cnt_d   = data_cnt_q;
    code_valid_d = 1'b0;
    def_valid_d  = 1'b0;
    data_valid_d = 1'b0;
    error_d      = error_q;
    take_data    = 1'b0;

    if (byte_valid_i) begin
      case (state_q)
        i3c_ccc_pkg::CODE: begin
          code_valid_d = 1'b1;
          state_d      = i3c_ccc_pkg::DEFBYTE;
        end
        // Second byte: defining byte only if the handler asks for one
        i3c_ccc_pkg::DEFBYTE: begin
          if (needs_defining_byte_i) begin
            def_valid_d = 1'b1;
            state_d     = i3c_ccc_pkg::DATA;
          end else begin
            take_data = 1'b1;
          end
        end
        i3c_ccc_pkg::DATA: take_data = 1'b1;
        default: ;
      endcase
    end

    // Count data bytes against the handler limit
    if (take_data) begin
      if (data_cnt_q >= command_max_bytes_i) begin
        state_d = i3c_ccc_pkg::OVERRUN;
        error_d = 1'b1;
      end else begin
        data_valid_d = 1'b1;
        data_cnt_d   = data_cnt_q + i3c_ccc_pkg::ccc_count_t'(1);
        state_d      = i3c_ccc_pkg::DATA;
      end
    end

    // A new frame restarts everything, including the sticky error
    if (frame_start_i) begin
      state_d      = i3c_ccc_pkg::CODE;
      data_cnt_d   = '0;
      code_valid_d = 1'b0;
      def_valid_d  = 1'b0;
      data_valid_d = 1'b0;
      error_d      = 1'b0;
    end else if (frame_end_i) begin
      state_d = i3c_ccc_pkg::IDLE;
    end
  end

  // Frame end only counts inside a frame
  assign frame_done_d = frame_end_i && !frame_start_i && (state_q != i3c_ccc_pkg::IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= i3c_ccc_pkg::IDLE;
      data_cnt_q   <= '0;
      code_valid_q <= 1'b0;
      def_valid_q  <= 1'b0;
      data_valid_q <= 1'b0;
      frame_done_q <= 1'b0;
      error_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      data_cnt_q   <= data_cnt_d;
      code_valid_q <= code_valid_d;
      def_valid_q  <= def_valid_d;
      data_valid_q <= data_valid_d;
      frame_done_q <= frame_done_d;
      error_q      <= error_d;
    end
  end

  // One byte register serves all three fields, the strobes tell them apart
  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      byte_q <= byte_i;
    end
  end

  assign command_code_o        = byte_q;
  assign command_code_valid_o  = code_valid_q;
  assign defining_byte_o       = byte_q;
  assign defining_byte_valid_o = def_valid_q;
  assign command_data_o        = byte_q;
  assign command_data_valid_o  = data_valid_q;
  assign frame_done_o          = frame_done_q;
  assign protocol_error_o      = error_q;

endmodule

// ==== design/ccc_handler.sv ====
// GETMRL/GETMWL answer with one size byte only; limits bypass the latch so the parser sees them early
`timescale 1ns/10ps
`include "i3c_ccc_macros.svh"

module ccc_handler (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_ccc_pkg::ccc_byte_t   command_code_i,
  input  logic                     command_code_valid_i,
  input  i3c_ccc_pkg::ccc_byte_t   defining_byte_i,
  input  logic                     defining_byte_valid_i,
  input  i3c_ccc_pkg::ccc_byte_t   command_data_i,
  input  logic                     command_data_valid_i,
  input  logic                     frame_done_i,
  input  i3c_ccc_pkg::queue_size_t queue_size_i,
  output i3c_ccc_pkg::ccc_byte_t   response_byte_o,
  output logic                     response_valid_o,
  output logic                     enter_hdr_o,
  output i3c_ccc_pkg::rst_action_t rst_action_o,
  output logic                     rst_action_valid_o,
  output logic                     needs_defining_byte_o,
  output i3c_ccc_pkg::ccc_count_t  command_min_bytes_o,
  output i3c_ccc_pkg::ccc_count_t  command_max_bytes_o
);

  i3c_ccc_pkg::ccc_byte_t command_code;
  i3c_ccc_pkg::ccc_byte_t defining_byte;
  logic                   defining_byte_valid;
  logic                   clear_command_code;
  i3c_ccc_pkg::ccc_byte_t limit_code;

  i3c_ccc_pkg::ccc_byte_t tx_data_buffer_size;
  i3c_ccc_pkg::ccc_byte_t rx_data_buffer_size;

  // Control part of the latch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      command_code        <= '0;
      defining_byte_valid <= 1'b0;
    end else begin
      if (clear_command_code) begin
        command_code <= '0;
      end else if (command_code_valid_i) begin
        command_code <= command_code_i;
      end
      defining_byte_valid <= defining_byte_valid_i;
    end
  end

  // Defining byte payload
  always_ff @(posedge clk_i) begin
    if (defining_byte_valid_i) begin
      defining_byte <= defining_byte_i;
    end
  end

  // Queue size register fields, TX size on top, RX size below it
  assign tx_data_buffer_size = queue_size_i[31:24];
  assign rx_data_buffer_size = queue_size_i[23:16];

  // Response and side effects of the latched code
  always_comb begin
    response_byte_o    = '0;
    response_valid_o   = 1'b0;
    enter_hdr_o        = 1'b0;
    rst_action_o       = `I3C_RSTACT_NONE;
    rst_action_valid_o = 1'b0;
    clear_command_code = frame_done_i;
    case (command_code)
      `I3C_DIRECT_GETMRL: begin
        response_byte_o  = rx_data_buffer_size;
        response_valid_o = 1'b1;
      end
      `I3C_DIRECT_GETMWL: begin
        response_byte_o  = tx_data_buffer_size;
        response_valid_o = 1'b1;
      end
      // Single-cycle pulse, the code goes away on the next edge
      `I3C_BCAST_ENTHDR0: begin
        enter_hdr_o        = 1'b1;
        clear_command_code = 1'b1;
      end
      `I3C_BCAST_RSTACT, `I3C_DIRECT_RSTACT: begin
        if (defining_byte_valid) begin
          rst_action_o       = defining_byte;
          rst_action_valid_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // Parser needs the limits while the code is still being latched
  assign limit_code = command_code_valid_i ? command_code_i : command_code;

  always_comb begin
    needs_defining_byte_o = 1'b0;
    command_min_bytes_o   = '0;
    command_max_bytes_o   = '0;
    case (limit_code)
      `I3C_BCAST_RSTACT, `I3C_DIRECT_RSTACT: begin
        needs_defining_byte_o = 1'b1;
        command_min_bytes_o   = i3c_ccc_pkg::ccc_count_t'(1);
        command_max_bytes_o   = i3c_ccc_pkg::ccc_count_t'(1);
      end
      default: ;
    endcase
  end

endmodule

// ==== design/ccc_target_state.sv ====
// Target reset with no stored action gives a peripheral reset; only one reset pulse per pattern
`timescale 1ns/10ps
`include "i3c_ccc_macros.svh"

module ccc_target_state (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enter_hdr_i,
  input  logic                     hdr_exit_i,
  input  i3c_ccc_pkg::rst_action_t rst_action_i,
  input  logic                     rst_action_valid_i,
  input  logic                     target_reset_i,
  output logic                     hdr_active_o,
  output i3c_ccc_pkg::rst_action_t pending_rst_action_o,
  output logic                     peripheral_reset_o,
  output logic                     chip_reset_o
);

  logic                     hdr_active_q;
  i3c_ccc_pkg::rst_action_t pending_q;
  logic                     periph_rst_q;
  logic                     chip_rst_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_active_q <= 1'b0;
      pending_q    <= `I3C_RSTACT_NONE;
      periph_rst_q <= 1'b0;
      chip_rst_q   <= 1'b0;
    end else begin
      periph_rst_q <= 1'b0;
      chip_rst_q   <= 1'b0;

      // HDR mode flag, exit wins over entry
      if (hdr_exit_i) begin
        hdr_active_q <= 1'b0;
      end else if (enter_hdr_i) begin
        hdr_active_q <= 1'b1;
      end

      // Reset pattern consumes the stored action
      if (target_reset_i) begin
        if (pending_q == `I3C_RSTACT_CHIP) begin
          chip_rst_q <= 1'b1;
        end else begin
          // PERIPH, NONE and unknown codes all mean peripheral reset
          periph_rst_q <= 1'b1;
        end
        pending_q <= `I3C_RSTACT_NONE;
      end

      // A fresh RSTACT on the same cycle is kept for the next pattern
      if (rst_action_valid_i) begin
        pending_q <= rst_action_i;
      end
    end
  end

  assign hdr_active_o         = hdr_active_q;
  assign pending_rst_action_o = pending_q;
  assign peripheral_reset_o   = periph_rst_q;
  assign chip_reset_o         = chip_rst_q;

endmodule

// ==== design/i3c_ccc_macros.svh ====
// Only GETMRL, GETMWL, ENTHDR0 and RSTACT are decoded; byte limit counts saturate at 2 bits
`ifndef I3C_CCC_MACROS_SVH
`define I3C_CCC_MACROS_SVH

// Command codes, bit 7 set marks a direct CCC

// Direct GETMRL, read of max read length
`define I3C_DIRECT_GETMRL 8'h8C

// Direct GETMWL, read of max write length
`define I3C_DIRECT_GETMWL 8'h8B

// Broadcast entry into HDR mode 0
`define I3C_BCAST_ENTHDR0 8'h20

// Target reset action, broadcast and direct forms
`define I3C_BCAST_RSTACT 8'h2A
`define I3C_DIRECT_RSTACT 8'h9A

// RSTACT defining byte values

// No reset requested
`define I3C_RSTACT_NONE 8'h00

// Reset the peripheral only
`define I3C_RSTACT_PERIPH 8'h01

// Reset the whole target chip
`define I3C_RSTACT_CHIP 8'h02

// Byte limit width

// Enough for the largest limit of any decoded CCC
`define I3C_CCC_CNT_W 2

`endif

// ==== design/i3c_ccc_pkg.sv ====
// Types shared by the CCC path; limit width comes from the macros header
`include "i3c_ccc_macros.svh"

package i3c_ccc_pkg;

  // One byte as seen on the bus
  typedef logic [7:0] ccc_byte_t;

  // Queue size register, from the top byte
  // TX buffer size, RX buffer size, IBI status size, cmd/resp queue size
  typedef logic [31:0] queue_size_t;

  // Data byte limit count
  typedef logic [`I3C_CCC_CNT_W-1:0] ccc_count_t;

  // RSTACT reset action code
  typedef logic [7:0] rst_action_t;

  // Frame parser states
  typedef enum logic [2:0] {
    IDLE,
    CODE,
    DEFBYTE,
    DATA,
    OVERRUN
  } parser_state_e;

endpackage

// ==== design/i3c_ccc_top.sv ====
// Byte stream must already be framed; no back-pressure, at most one byte per cycle
`timescale 1ns/10ps

module i3c_ccc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     frame_start_i,
  input  logic                     frame_end_i,
  input  i3c_ccc_pkg::ccc_byte_t   byte_i,
  input  logic                     byte_valid_i,
  input  i3c_ccc_pkg::queue_size_t queue_size_i,
  input  logic                     hdr_exit_i,
  input  logic                     target_reset_i,
  output i3c_ccc_pkg::ccc_byte_t   response_byte_o,
  output logic                     response_valid_o,
  output logic                     hdr_active_o,
  output i3c_ccc_pkg::rst_action_t pending_rst_action_o,
  output logic                     peripheral_reset_o,
  output logic                     chip_reset_o,
  output logic                     protocol_error_o
);

  i3c_ccc_pkg::ccc_byte_t   command_code;
  logic                     command_code_valid;
  i3c_ccc_pkg::ccc_byte_t   defining_byte;
  logic                     defining_byte_valid;
  i3c_ccc_pkg::ccc_byte_t   command_data;
  logic                     command_data_valid;
  logic                     frame_done;
  logic                     needs_defining_byte;
  i3c_ccc_pkg::ccc_count_t  command_max_bytes;
  logic                     enter_hdr;
  i3c_ccc_pkg::rst_action_t rst_action;
  logic                     rst_action_valid;

  ccc_frame_parser u_parser (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .frame_start_i         (frame_start_i),
    .frame_end_i           (frame_end_i),
    .byte_i                (byte_i),
    .byte_valid_i          (byte_valid_i),
    .needs_defining_byte_i (needs_defining_byte),
    .command_max_bytes_i   (command_max_bytes),
    .command_code_o        (command_code),
    .command_code_valid_o  (command_code_valid),
    .defining_byte_o       (defining_byte),
    .defining_byte_valid_o (defining_byte_valid),
    .command_data_o        (command_data),
    .command_data_valid_o  (command_data_valid),
    .frame_done_o          (frame_done),
    .protocol_error_o      (protocol_error_o)
  );

  // Minimum byte count is not checked on this path
  ccc_handler u_handler (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .command_code_i        (command_code),
    .command_code_valid_i  (command_code_valid),
    .defining_byte_i       (defining_byte),
    .defining_byte_valid_i (defining_byte_valid),
    .command_data_i        (command_data),
    .command_data_valid_i  (command_data_valid),
    .frame_done_i          (frame_done),
    .queue_size_i          (queue_size_i),
    .response_byte_o       (response_byte_o),
    .response_valid_o      (response_valid_o),
    .enter_hdr_o           (enter_hdr),
    .rst_action_o          (rst_action),
    .rst_action_valid_o    (rst_action_valid),
    .needs_defining_byte_o (needs_defining_byte),
    .command_min_bytes_o   (),
    .command_max_bytes_o   (command_max_bytes)
  );

  ccc_target_state u_target_state (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .enter_hdr_i          (enter_hdr),
    .hdr_exit_i           (hdr_exit_i),
    .rst_action_i         (rst_action),
    .rst_action_valid_i   (rst_action_valid),
    .target_reset_i       (target_reset_i),
    .hdr_active_o         (hdr_active_o),
    .pending_rst_action_o (pending_rst_action_o),
    .peripheral_reset_o   (peripheral_reset_o),
    .chip_reset_o         (chip_reset_o)
  );

endmodule

// ==== dv/tb_i3c_ccc_vectors.svh ====
// One row per frame; bytes are sent in order from index 0, and only len of them are used
`ifndef TB_I3C_CCC_VECTORS_SVH
`define TB_I3C_CCC_VECTORS_SVH

`include "i3c_ccc_macros.svh"

// What the testbench does after the frame
localparam logic [1:0] FOLLOW_NONE  = 2'd0;
localparam logic [1:0] FOLLOW_RESET = 2'd1;
localparam logic [1:0] FOLLOW_EXIT  = 2'd2;

localparam int NUM_ROWS = 13;

typedef struct packed {
  logic [2:0]                   len;
  i3c_ccc_pkg::ccc_byte_t [0:3] bytes;
  i3c_ccc_pkg::queue_size_t     qsize;
  logic [1:0]                   follow;
  logic                         exp_resp_valid;
  i3c_ccc_pkg::ccc_byte_t       exp_resp;
  logic                         exp_hdr;
  i3c_ccc_pkg::rst_action_t     exp_pending;
  logic                         exp_periph;
  logic                         exp_chip;
  logic                         exp_error;
} vector_t;

vector_t rows [NUM_ROWS];

// Columns: len, bytes 0..3, queue size, follow,
// then resp valid, resp byte, hdr, pending action, periph pulse, chip pulse, error
task automatic load_vectors();
  rows[0]  = {3'd1, `I3C_DIRECT_GETMRL, 8'h00, 8'h00, 8'h00, 32'h4433_2211, FOLLOW_NONE,
              1'b1, 8'h33, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0};
  rows[1]  = {3'd1, `I3C_DIRECT_GETMWL, 8'h00, 8'h00, 8'h00, 32'hA5C3_0F1E, FOLLOW_NONE,
              1'b1, 8'hA5, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0};
  rows[2]  = {3'd1, `I3C_DIRECT_GETMRL, 8'h00, 8'h00, 8'h00, 32'hA5C3_0F1E, FOLLOW_NONE,
              1'b1, 8'hC3, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0};
  rows[3]  = {3'd1, `I3C_BCAST_ENTHDR0, 8'h00, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_EXIT,
              1'b0, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0};
  rows[4]  = {3'd2, `I3C_BCAST_RSTACT, 8'h01, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_RESET,
              1'b0, 8'h00, 1'b0, 8'h01, 1'b1, 1'b0, 1'b0};
  rows[5]  = {3'd2, `I3C_DIRECT_RSTACT, 8'h02, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_RESET,
              1'b0, 8'h00, 1'b0, 8'h02, 1'b0, 1'b1, 1'b0};
  // Reset with nothing pending
  rows[6]  = {3'd1, `I3C_DIRECT_GETMWL, 8'h00, 8'h00, 8'h00, 32'h0102_0304, FOLLOW_RESET,
              1'b1, 8'h01, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0};
  rows[7]  = {3'd4, `I3C_BCAST_RSTACT, 8'h01, 8'h55, 8'h66, 32'h0000_0000, FOLLOW_RESET,
              1'b0, 8'h00, 1'b0, 8'h01, 1'b1, 1'b0, 1'b1};
  rows[8]  = {3'd2, 8'h3F, 8'h12, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_NONE,
              1'b0, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1};
  rows[9]  = {3'd1, `I3C_DIRECT_GETMRL, 8'h00, 8'h00, 8'h00, 32'h0102_0304, FOLLOW_NONE,
              1'b1, 8'h02, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0};
  rows[10] = {3'd2, `I3C_DIRECT_RSTACT, 8'h02, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_NONE,
              1'b0, 8'h00, 1'b0, 8'h02, 1'b0, 1'b0, 1'b0};
  // Unknown code must leave the pending chip reset alone
  rows[11] = {3'd2, 8'hE5, 8'h77, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_RESET,
              1'b0, 8'h00, 1'b0, 8'h02, 1'b0, 1'b1, 1'b1};
  rows[12] = {3'd2, `I3C_DIRECT_RSTACT, 8'h00, 8'h00, 8'h00, 32'h0000_0000, FOLLOW_RESET,
              1'b0, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0};
endtask

`endif

// ==== dv/tb_i3c_ccc.sv ====
// Frames are played back to back from the vector table; DUT state carries over between rows
`timescale 1ns/10ps

module tb_i3c_ccc;

  `include "tb_i3c_ccc_vectors.svh"

  localparam int TIMEOUT_CYCLES = 40;
  localparam int SEL_RESP = 0;
  localparam int SEL_HDR  = 1;
  localparam int SEL_ERR  = 2;
  localparam int SEL_RST  = 3;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     frame_start_i;
  logic                     frame_end_i;
  i3c_ccc_pkg::ccc_byte_t   byte_i;
  logic                     byte_valid_i;
  i3c_ccc_pkg::queue_size_t queue_size_i;
  logic                     hdr_exit_i;
  logic                     target_reset_i;
  i3c_ccc_pkg::ccc_byte_t   response_byte_o;
  logic                     response_valid_o;
  logic                     hdr_active_o;
  i3c_ccc_pkg::rst_action_t pending_rst_action_o;
  logic                     peripheral_reset_o;
  logic                     chip_reset_o;
  logic                     protocol_error_o;

  int          row_idx;
  int          mismatch_errors = 0;
  int          timeout_errors = 0;
  int unsigned resp_cnt = 0;
  int unsigned periph_cnt = 0;
  int unsigned chip_cnt = 0;
  int unsigned resp_snap;
  int unsigned periph_snap;
  int unsigned chip_snap;

  i3c_ccc_top uut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .frame_start_i        (frame_start_i),
    .frame_end_i          (frame_end_i),
    .byte_i               (byte_i),
    .byte_valid_i         (byte_valid_i),
    .queue_size_i         (queue_size_i),
    .hdr_exit_i           (hdr_exit_i),
    .target_reset_i       (target_reset_i),
    .response_byte_o      (response_byte_o),
    .response_valid_o     (response_valid_o),
    .hdr_active_o         (hdr_active_o),
    .pending_rst_action_o (pending_rst_action_o),
    .peripheral_reset_o   (peripheral_reset_o),
    .chip_reset_o         (chip_reset_o),
    .protocol_error_o     (protocol_error_o)
  );

  always #2 clk_i = ~clk_i;

  // Cycle counts of valid response and reset pulses
  always @(negedge clk_i) begin
    if (response_valid_o) resp_cnt <= resp_cnt + 1;
    if (peripheral_reset_o) periph_cnt <= periph_cnt + 1;
    if (chip_reset_o) chip_cnt <= chip_cnt + 1;
  end

  task automatic check_byte(input string name, input i3c_ccc_pkg::ccc_byte_t got,
                            input i3c_ccc_pkg::ccc_byte_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("FAIL %s row %0d: got 0x%02h, expected 0x%02h", name, row_idx, got, exp);
    end
  endtask

  task automatic check_action(input string name, input i3c_ccc_pkg::rst_action_t got,
                              input i3c_ccc_pkg::rst_action_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("FAIL %s row %0d: got 0x%02h, expected 0x%02h", name, row_idx, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("FAIL %s row %0d: got 0x%0h, expected 0x%0h", name, row_idx, got, exp);
    end
  endtask

  function automatic logic signal_level(input int sel);
    case (sel)
      SEL_RESP: signal_level = response_valid_o;
      SEL_HDR:  signal_level = hdr_active_o;
      SEL_ERR:  signal_level = protocol_error_o;
      default:  signal_level = (periph_cnt != periph_snap) || (chip_cnt != chip_snap);
    endcase
  endfunction

  // Samples on the falling edge, where outputs are settled
  task automatic wait_level(input int sel, input logic level, input string what);
    int  n;
    logic hit;
    hit = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !hit; n++) begin
      @(negedge clk_i);
      hit = (signal_level(sel) === level);
    end
    if (!hit) begin
      timeout_errors++;
      $display("Timeout in row %0d: %s never reached %0b", row_idx, what, level);
    end
  endtask

  task automatic wait_action(input i3c_ccc_pkg::rst_action_t exp);
    int  n;
    logic hit;
    hit = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !hit; n++) begin
      @(negedge clk_i);
      hit = (pending_rst_action_o === exp);
    end
    if (!hit) begin
      timeout_errors++;
      $display("Timeout in row %0d: pending reset action never reached %02h", row_idx, exp);
    end
  endtask

  task automatic play_row(input vector_t v);
    int i;
    resp_snap   = resp_cnt;
    periph_snap = periph_cnt;
    chip_snap   = chip_cnt;
    @(posedge clk_i);
    queue_size_i  <= v.qsize;
    frame_start_i <= 1'b1;
    for (i = 0; i < v.len; i++) begin
      @(posedge clk_i);
      frame_start_i <= 1'b0;
      byte_i        <= v.bytes[i];
      byte_valid_i  <= 1'b1;
    end
    @(posedge clk_i);
    frame_start_i <= 1'b0;
    byte_valid_i  <= 1'b0;
    // Response only lives until frame end
    if (v.exp_resp_valid) begin
      wait_level(SEL_RESP, 1'b1, "response_valid_o");
      check_byte("response_byte_o", response_byte_o, v.exp_resp);
    end
    @(posedge clk_i);
    frame_end_i <= 1'b1;
    @(posedge clk_i);
    frame_end_i <= 1'b0;
    wait_level(SEL_RESP, 1'b0, "response_valid_o after frame end");
    check_bit("response_valid_o", resp_cnt != resp_snap, v.exp_resp_valid);
    wait_level(SEL_HDR, v.exp_hdr, "hdr_active_o");
    check_bit("hdr_active_o", hdr_active_o, v.exp_hdr);
    wait_level(SEL_ERR, v.exp_error, "protocol_error_o");
    check_bit("protocol_error_o", protocol_error_o, v.exp_error);
    wait_action(v.exp_pending);
    check_action("pending_rst_action_o", pending_rst_action_o, v.exp_pending);
    if (v.follow == FOLLOW_RESET) begin
      @(posedge clk_i);
      target_reset_i <= 1'b1;
      @(posedge clk_i);
      target_reset_i <= 1'b0;
      wait_level(SEL_RST, 1'b1, "a reset pulse");
      wait_action(`I3C_RSTACT_NONE);
      check_action("pending_rst_action_o", pending_rst_action_o, `I3C_RSTACT_NONE);
    end else if (v.follow == FOLLOW_EXIT) begin
      @(posedge clk_i);
      hdr_exit_i <= 1'b1;
      @(posedge clk_i);
      hdr_exit_i <= 1'b0;
      wait_level(SEL_HDR, 1'b0, "hdr_active_o after exit");
      check_bit("hdr_active_o", hdr_active_o, 1'b0);
    end
    check_bit("peripheral_reset_o", periph_cnt != periph_snap, v.exp_periph);
    check_bit("chip_reset_o", chip_cnt != chip_snap, v.exp_chip);
  endtask

  initial begin
    int r;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    frame_start_i  = 1'b0;
    frame_end_i    = 1'b0;
    byte_i         = '0;
    byte_valid_i   = 1'b0;
    queue_size_i   = '0;
    hdr_exit_i     = 1'b0;
    target_reset_i = 1'b0;
    row_idx        = 0;
    load_vectors();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      row_idx = r;
      play_row(rows[r]);
    end
    repeat (4) @(posedge clk_i);
    $display("Mismatches: %0d, timeouts: %0d", mismatch_errors, timeout_errors);
    if (mismatch_errors == 0 && timeout_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+design
+incdir+dv
design/i3c_ccc_pkg.sv
design/ccc_frame_parser.sv
design/ccc_handler.sv
design/ccc_target_state.sv
design/i3c_ccc_top.sv
dv/tb_i3c_ccc.sv
